// ==== filelist.f ====
logic/adc_pkg.sv
logic/link_pkg.sv
logic/pin.sv
logic/cmd_receiver.sv
logic/adc_capture.sv
logic/frame_sender.sv
logic/acq_top.sv
tb/tb_clock.sv
tb/acq_asserts.sv
tb/acq_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= acq_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/acq_tb.sv ====
`timescale 1ns/1ps

module acq_tb
    import adc_pkg::*;
    import link_pkg::*;
();

    localparam int BIT_CYCLES = 4;
    localparam int SCLK_DIV   = 2;
    localparam int TIMEOUT    = 1000;

    logic                    clk;
    logic                    rst_n;
    logic [1:0]              com_rxd_p;
    logic [1:0]              com_rxd_n;
    logic                    com_rxf;
    logic [NUM_CHANNELS-1:0] adc_miso_p = '0;
    logic [NUM_CHANNELS-1:0] adc_miso_n = '1;
    logic [NUM_LANES-1:0]    com_txd_p;
    logic [NUM_LANES-1:0]    com_txd_n;
    logic                    com_txf;
    logic [NUM_CHANNELS-1:0] adc_cs_p;
    logic [NUM_CHANNELS-1:0] adc_cs_n;
    logic [NUM_CHANNELS-1:0] adc_mosi_p;
    logic [NUM_CHANNELS-1:0] adc_mosi_n;
    logic [NUM_CHANNELS-1:0] adc_sclk_p;
    logic [NUM_CHANNELS-1:0] adc_sclk_n;
    logic                    link_fault;
    logic                    cmd_valid;

    integer                  seed = 26434;
    logic [15:0]             adc_word [NUM_CHANNELS];
    cmd_t                    cur_cmd;
    logic [63:0]             exp_q [$];
    logic [63:0]             got_q [$];
    logic [15:0]             rx_word [NUM_LANES];
    int                      rx_bits = 0;
    int                      frames_seen = 0;
    int                      valid_seen = 0;
    logic [NUM_CHANNELS-1:0] cs_prev = '1;
    logic [NUM_CHANNELS-1:0] sclk_prev = '0;
    int                      bit_pos [NUM_CHANNELS];

    tb_clock u_clock (
        .clk (clk)
    );

    acq_top #(
        .BIT_CYCLES (BIT_CYCLES),
        .SCLK_DIV   (SCLK_DIV)
    ) u_dut (.*);

    // lane word: tag on top, sample only where the mask selects the adc.
    function automatic lane_word_t expected_lane(cmd_t c, int lane, logic [15:0] word);
        lane_word_t w;
        w.tag    = c.tag;
        w.sample = c.mask[lane] ? word[11:0] : 12'h000;
        return w;
    endfunction

    function automatic logic [63:0] expected_frame(cmd_t c);
        logic [63:0] f;
        for (int i = 0; i < NUM_LANES; i++) begin
            f[i*16 +: 16] = expected_lane(c, i, adc_word[i]);
        end
        return f;
    endfunction

    // adc model: msb out when cs falls, next bit on each sclk fall.
    always @(adc_cs_p or adc_sclk_p) begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (cs_prev[i] === 1'b1 && adc_cs_p[i] === 1'b0) begin
                bit_pos[i] = 15;
                adc_miso_p[i] <= adc_word[i][15];
                adc_miso_n[i] <= ~adc_word[i][15];
            end else if (adc_cs_p[i] === 1'b0 && sclk_prev[i] === 1'b1
                         && adc_sclk_p[i] === 1'b0 && bit_pos[i] > 0) begin
                bit_pos[i] = bit_pos[i] - 1;
                adc_miso_p[i] <= adc_word[i][bit_pos[i]];
                adc_miso_n[i] <= ~adc_word[i][bit_pos[i]];
            end
        end
        cs_prev   = adc_cs_p;
        sclk_prev = adc_sclk_p;
    end

    // rebuild the lane words while com_txf is high.
    always @(posedge clk) begin
        if (com_txf) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                rx_word[i] = {rx_word[i][14:0], com_txd_p[i]};
            end
            rx_bits = rx_bits + 1;
            if (rx_bits == 16) begin
                got_q.push_back({rx_word[3], rx_word[2], rx_word[1], rx_word[0]});
                rx_bits = 0;
            end
        end
        if (cmd_valid) begin
            valid_seen = valid_seen + 1;
        end
    end

    always @(negedge clk) begin
        logic [63:0] got;
        if (rst_n === 1'b1) begin
            // n carries the inverse of p on every output pair.
            check_equal(64'(com_txd_p ^ com_txd_n), 64'hf, "com_txd pair");
            check_equal(64'(adc_mosi_p ^ adc_mosi_n), 64'hf, "adc_mosi pair");
            check_equal(64'(adc_sclk_p ^ adc_sclk_n), 64'hf, "adc_sclk pair");
        end
        if (got_q.size() != 0) begin
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("a frame arrived with no fire pending at %0t ns", $time);
                $display("RESULT: FAIL");
                $fatal(1, "unexpected frame");
            end
            check_equal(got, exp_q.pop_front(), "frame");
            frames_seen = frames_seen + 1;
        end
    end

    task automatic check_equal(logic [63:0] got, logic [63:0] exp, string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic timeout_fail(string what);
        $display("timed out waiting for %s at %0t ns", what, $time);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // start bit, data lsb first, stop bit.
    task automatic send_cmd(cmd_t c, logic stop);
        logic [9:0] bits;
        int         target;
        int         t;
        bits   = {stop, c, 1'b0};
        target = valid_seen + 1;
        for (int k = 0; k < 10; k++) begin
            com_rxd_p[0] <= bits[k];
            com_rxd_n[0] <= ~bits[k];
            repeat (BIT_CYCLES) @(posedge clk);
        end
        com_rxd_p[0] <= 1'b1;
        com_rxd_n[0] <= 1'b0;
        if (stop) begin
            t = 0;
            while (valid_seen < target) begin
                t++;
                if (t > TIMEOUT) timeout_fail("cmd_valid");
                @(posedge clk);
            end
            cur_cmd = c;
        end else begin
            repeat (4 * BIT_CYCLES) @(posedge clk);
            check_equal(64'(valid_seen), 64'(target - 1), "dropped byte cmd_valid count");
        end
    endtask

    task automatic run_frame(logic second_fire);
        integer                  r;
        int                      target;
        int                      t;
        logic [NUM_CHANNELS-1:0] idle_mask;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            r = $random(seed);
            adc_word[i] = r[15:0];
        end
        target    = frames_seen + 1;
        idle_mask = ~cur_cmd.mask;
        exp_q.push_back(expected_frame(cur_cmd));
        com_rxf <= 1'b1;
        repeat (2) @(posedge clk);
        com_rxf <= 1'b0;
        t = 0;
        // idle is every cs high with every mosi low.
        while (adc_cs_p == 4'hf && adc_mosi_p == 4'h0) begin
            t++;
            if (t > TIMEOUT) timeout_fail("conversion start");
            @(posedge clk);
        end
        // adcs outside the mask stay deselected and powered down.
        check_equal(64'(adc_cs_p), 64'(idle_mask), "adc_cs_p");
        check_equal(64'(adc_mosi_p), 64'(idle_mask), "adc_mosi_p");
        if (second_fire) begin
            repeat (2) @(posedge clk);
            com_rxf <= 1'b1;
            repeat (2) @(posedge clk);
            com_rxf <= 1'b0;
        end
        t = 0;
        while (frames_seen < target) begin
            t++;
            if (t > TIMEOUT) timeout_fail("frame");
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        integer r;
        int     t;
        rst_n     <= 1'b0;
        com_rxd_p <= 2'b11;
        com_rxd_n <= 2'b00;
        com_rxf   <= 1'b0;
        cur_cmd   = '{tag: 4'h0, mask: 4'hf};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        run_frame(1'b0);
        send_cmd('{tag: 4'h5, mask: 4'b0101}, 1'b1);
        run_frame(1'b0);
        send_cmd('{tag: 4'ha, mask: 4'hf}, 1'b0);
        run_frame(1'b0);

        run_frame(1'b1);
        repeat (100) @(posedge clk);

        // lane 1 pair made invalid.
        com_rxd_n[1] <= com_rxd_p[1];
        t = 0;
        while (!link_fault) begin
            t++;
            if (t > TIMEOUT) timeout_fail("link_fault to rise");
            @(posedge clk);
        end
        com_rxd_n[1] <= ~com_rxd_p[1];
        t = 0;
        while (link_fault) begin
            t++;
            if (t > TIMEOUT) timeout_fail("link_fault to clear");
            @(posedge clk);
        end

        for (int k = 0; k < 20; k++) begin
            r = $random(seed);
            send_cmd(cmd_t'(r[7:0]), 1'b1);
            run_frame(1'b0);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb/acq_asserts.sv ====
`timescale 1ns/1ps

module acq_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       com_txf,
    input logic [3:0] adc_cs_p,
    input logic [3:0] adc_cs_n
);

    int txf_len = 0;

    // cycles that com_txf has been high so far.
    always @(posedge clk) begin
        txf_len <= com_txf ? txf_len + 1 : 0;
    end

    a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(com_txf) |-> txf_len == 16)
        else $error("frame length was %0d cycles", txf_len);

    a_cs_reset: assert property (@(posedge clk) !rst_n |=> adc_cs_p == 4'hf)
        else $error("chip selects not idle after reset");

    a_cs_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(com_txf) |-> adc_cs_p == 4'hf)
        else $error("chip selects not idle at frame start");

    a_cs_pair: assert property (@(posedge clk) disable iff (!rst_n)
        adc_cs_n == ~adc_cs_p)
        else $error("adc_cs_n is not the inverse of adc_cs_p");

endmodule

bind acq_top acq_asserts u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .com_txf  (com_txf),
    .adc_cs_p (adc_cs_p),
    .adc_cs_n (adc_cs_n)
);

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== logic/acq_top.sv ====
`timescale 1ns/1ps

module acq_top
    import adc_pkg::*;
    import link_pkg::*;
#(
    parameter int BIT_CYCLES = 4,
    parameter int SCLK_DIV   = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [NUM_LANES-1:0]    com_txd_p,
    output logic [NUM_LANES-1:0]    com_txd_n,
    input  logic [1:0]              com_rxd_p,
    input  logic [1:0]              com_rxd_n,
    input  logic                    com_rxf,
    output logic                    com_txf,
    input  logic [NUM_CHANNELS-1:0] adc_miso_p,
    input  logic [NUM_CHANNELS-1:0] adc_miso_n,
    output logic [NUM_CHANNELS-1:0] adc_cs_p,
    output logic [NUM_CHANNELS-1:0] adc_cs_n,
    output logic [NUM_CHANNELS-1:0] adc_mosi_p,
    output logic [NUM_CHANNELS-1:0] adc_mosi_n,
    output logic [NUM_CHANNELS-1:0] adc_sclk_p,
    output logic [NUM_CHANNELS-1:0] adc_sclk_n,
    output logic                    link_fault,
    output logic                    cmd_valid
);

    logic [NUM_LANES-1:0]    pin_txd;
    logic                    fire_send;
    logic                    pin_rxd;
    logic                    fire_read;
    logic [NUM_CHANNELS-1:0] pin_cs;
    logic [NUM_CHANNELS-1:0] pin_sclk;
    logic [NUM_CHANNELS-1:0] pin_mosi;
    logic [NUM_CHANNELS-1:0] pin_miso;
    cmd_t                    cmd;
    sample_set_t             samples;
    logic                    done;

    pin u_pin (
        .clk        (clk),
        .rst_n      (rst_n),
        .com_txd_p  (com_txd_p),
        .com_txd_n  (com_txd_n),
        .com_rxd_p  (com_rxd_p),
        .com_rxd_n  (com_rxd_n),
        .com_rxf    (com_rxf),
        .com_txf    (com_txf),
        .adc_miso_p (adc_miso_p),
        .adc_miso_n (adc_miso_n),
        .adc_cs_p   (adc_cs_p),
        .adc_cs_n   (adc_cs_n),
        .adc_mosi_p (adc_mosi_p),
        .adc_mosi_n (adc_mosi_n),
        .adc_sclk_p (adc_sclk_p),
        .adc_sclk_n (adc_sclk_n),
        .pin_txd    (pin_txd),
        .pin_rxd    (pin_rxd),
        .fire_send  (fire_send),
        .fire_read  (fire_read),
        .pin_cs     (pin_cs),
        .pin_sclk   (pin_sclk),
        .pin_mosi   (pin_mosi),
        .pin_miso   (pin_miso),
        .link_fault (link_fault)
    );

    cmd_receiver #(
        .BIT_CYCLES (BIT_CYCLES)
    ) u_cmd_receiver (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxd       (pin_rxd),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    adc_capture #(
        .SCLK_DIV (SCLK_DIV)
    ) u_adc_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .fire_read (fire_read),
        .mask      (cmd.mask),
        .miso      (pin_miso),
        .cs        (pin_cs),
        .sclk      (pin_sclk),
        .mosi      (pin_mosi),
        .samples   (samples),
        .done      (done)
    );

    frame_sender u_frame_sender (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .samples   (samples),
        .tag       (cmd.tag),
        .txd       (pin_txd),
        .fire_send (fire_send)
    );

endmodule

// ==== logic/frame_sender.sv ====
`timescale 1ns/1ps

module frame_sender
    import adc_pkg::*;
    import link_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 done,
    input  sample_set_t          samples,
    input  logic [TAG_BITS-1:0]  tag,
    output logic [NUM_LANES-1:0] txd,
    output logic                 fire_send
);

    localparam int WORD_BITS = $bits(lane_word_t);
    localparam int CNT_W = $clog2(WORD_BITS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WORD_BITS - 1);

    lane_word_t [NUM_LANES-1:0] word_q;
    logic [CNT_W-1:0]           bit_cnt;

    // fire_send frames exactly WORD_BITS cycles.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fire_send <= 1'b0;
            bit_cnt   <= '0;
        end else if (done) begin
            fire_send <= 1'b1;
            bit_cnt   <= '0;
        end else if (fire_send) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_LAST) begin
                fire_send <= 1'b0;
            end
        end
    end

    // load on done, then shift toward the msb.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (done) begin
                word_q[i] <= '{tag: tag, sample: samples.ch[i]};
            end else if (fire_send) begin
                word_q[i] <= {word_q[i][WORD_BITS-2:0], 1'b0};
            end
        end
    end

    // lanes sit low outside a frame.
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            txd[i] = fire_send & word_q[i][WORD_BITS-1];
        end
    end

endmodule

// ==== logic/adc_capture.sv ====
`timescale 1ns/1ps

module adc_capture
    import adc_pkg::*;
#(
    parameter int SCLK_DIV = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fire_read,
    input  logic [NUM_CHANNELS-1:0] mask,
    input  logic [NUM_CHANNELS-1:0] miso,
    output logic [NUM_CHANNELS-1:0] cs,
    output logic [NUM_CHANNELS-1:0] sclk,
    output logic [NUM_CHANNELS-1:0] mosi,
    output sample_set_t             samples,
    output logic                    done
);

    localparam int DIV_W = $clog2(SCLK_DIV + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCLK_DIV - 1);
    localparam int BIT_W = $clog2(SPI_WORD_BITS);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(SPI_WORD_BITS - 1);

    logic                    fire_d;
    logic                    busy;
    logic                    sclk_q;
    logic                    half_end;
    logic                    rise;
    logic                    fall;
    logic                    last_fall;
    logic [DIV_W-1:0]        div_cnt;
    logic [BIT_W-1:0]        bit_cnt;
    logic [NUM_CHANNELS-1:0] mask_q;
    logic [SPI_WORD_BITS-1:0] shift_q [NUM_CHANNELS];

    assign half_end  = busy && (div_cnt == DIV_LAST);
    assign rise      = half_end && !sclk_q;
    assign fall      = half_end && sclk_q;
    assign last_fall = fall && (bit_cnt == BIT_LAST);

    // one sclk shared by all adcs.
    assign sclk = {NUM_CHANNELS{sclk_q}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fire_d  <= 1'b0;
            busy    <= 1'b0;
            sclk_q  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            mask_q  <= '0;
            cs      <= '1;
            mosi    <= '0;
            done    <= 1'b0;
        end else begin
            fire_d <= fire_read;
            done   <= 1'b0;
            if (!busy) begin
                if (fire_read && !fire_d) begin
                    busy    <= 1'b1;
                    mask_q  <= mask;
                    cs      <= ~mask;
                    // power down for channels outside the mask.
                    mosi    <= ~mask;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else begin
                div_cnt <= half_end ? '0 : div_cnt + 1'b1;
                if (half_end) begin
                    sclk_q <= ~sclk_q;
                end
                if (fall) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (last_fall) begin
                    busy <= 1'b0;
                    cs   <= '1;
                    mosi <= '0;
                    done <= 1'b1;
                end
            end
        end
    end

    // miso taken on the rising sclk edge, msb first.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (rise) begin
                shift_q[i] <= {shift_q[i][SPI_WORD_BITS-2:0], miso[i]};
            end
            if (last_fall) begin
                samples.ch[i] <= mask_q[i] ? shift_q[i][SAMPLE_BITS-1:0] : '0;
            end
        end
    end

endmodule

// ==== logic/cmd_receiver.sv ====
`timescale 1ns/1ps

module cmd_receiver
    import link_pkg::*;
#(
    parameter int BIT_CYCLES = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic rxd,
    output cmd_t cmd,
    output logic cmd_valid
);

    localparam int CNT_W = $clog2(BIT_CYCLES + 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BIT_CYCLES / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(BIT_CYCLES - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             rxd_d;
    logic             tick;

    // start bit is sampled half a bit in, the rest a full bit apart.
    assign tick = (state == S_START) ? (cnt == HALF_LAST) : (cnt == FULL_LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            rxd_d     <= 1'b1;
            cmd       <= '{tag: '0, mask: '1};
            cmd_valid <= 1'b0;
        end else begin
            rxd_d     <= rxd;
            cmd_valid <= 1'b0;
            cnt       <= tick ? '0 : cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (rxd_d && !rxd) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    bit_idx <= '0;
                    if (tick) begin
                        // glitch, not a start bit.
                        state <= rxd ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    if (tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end
                end
                default: begin
                    if (tick) begin
                        if (rxd) begin
                            cmd       <= cmd_t'(shreg);
                            cmd_valid <= 1'b1;
                        end
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // lsb arrives first.
    always_ff @(posedge clk) begin
        if (state == S_DATA && tick) begin
            shreg <= {rxd, shreg[7:1]};
        end
    end

endmodule

// ==== logic/pin.sv ====
`timescale 1ns/1ps

module pin
    import link_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    output logic [NUM_LANES-1:0] com_txd_p,
    output logic [NUM_LANES-1:0] com_txd_n,
    input  logic [1:0]           com_rxd_p,
    input  logic [1:0]           com_rxd_n,
    input  logic                 com_rxf,
    output logic                 com_txf,

    input  logic [3:0]           adc_miso_p,
    input  logic [3:0]           adc_miso_n,
    output logic [3:0]           adc_cs_p,
    output logic [3:0]           adc_cs_n,
    output logic [3:0]           adc_mosi_p,
    output logic [3:0]           adc_mosi_n,
    output logic [3:0]           adc_sclk_p,
    output logic [3:0]           adc_sclk_n,

    input  logic [NUM_LANES-1:0] pin_txd,
    output logic                 pin_rxd,
    input  logic                 fire_send,
    output logic                 fire_read,

    input  logic [3:0]           pin_cs,
    input  logic [3:0]           pin_sclk,
    input  logic [3:0]           pin_mosi,
    output logic [3:0]           pin_miso,
    output logic                 link_fault
);

    logic pair_bad;

    // output pairs, n is the inverse of p.
    assign com_txd_p  = pin_txd;
    assign com_txd_n  = ~pin_txd;
    assign com_txf    = fire_send;
    assign adc_cs_p   = pin_cs;
    assign adc_cs_n   = ~pin_cs;
    assign adc_mosi_p = pin_mosi;
    assign adc_mosi_n = ~pin_mosi;
    assign adc_sclk_p = pin_sclk;
    assign adc_sclk_n = ~pin_sclk;

    // rxd lane 1 is only checked for a valid pair.
    assign pair_bad = (|(com_rxd_p ~^ com_rxd_n)) | (|(adc_miso_p ~^ adc_miso_n));

    always_ff @(posedge clk) begin
        pin_rxd   <= com_rxd_p[0];
        fire_read <= com_rxf;
        pin_miso  <= adc_miso_p;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link_fault <= 1'b0;
        end else begin
            link_fault <= pair_bad;
        end
    end

endmodule

// ==== logic/link_pkg.sv ====
package link_pkg;

    // serial lanes on the transmit link.
    localparam int NUM_LANES = 4;

    localparam int TAG_BITS = 4;

    // sample field carried in each lane word.
    localparam int LANE_SAMPLE_BITS = 12;

    // command byte as received, tag in the upper nibble.
    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [NUM_LANES-1:0] mask;
    } cmd_t;

    // one word per lane, sent msb first.
    typedef struct packed {
        logic [TAG_BITS-1:0]         tag;
        logic [LANE_SAMPLE_BITS-1:0] sample;
    } lane_word_t;

endpackage

// ==== logic/adc_pkg.sv ====
package adc_pkg;

    // adc channels converted together.
    localparam int NUM_CHANNELS = 4;

    // result width of one adc.
    localparam int SAMPLE_BITS = 12;

    // sclk periods per conversion.
    // the sample is the last SAMPLE_BITS received, msb first.
    localparam int SPI_WORD_BITS = 16;

    // leading bits dropped from each spi word.
    localparam int SPI_PAD_BITS = SPI_WORD_BITS - SAMPLE_BITS;

    typedef logic [SAMPLE_BITS-1:0] sample_t;

    // one result per channel, channel 0 in the low bits.
    typedef struct packed {
        sample_t [NUM_CHANNELS-1:0] ch;
    } sample_set_t;

endpackage
